/* Bender.yml */
package:
  name: audio_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - apb_pkg.sv
      - audio_pkg.sv
      - sample_fifo.sv
      - audio_regs.sv
      - usb_path.sv
      - playback_out.sv
      - led_pwm.sv
      - audio_ctrl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_audio_ctrl.sv

/* apb_pkg.sv */
`default_nettype none
`include "audio_consts.svh"

package apb_pkg;

    // requester side of an apb3 transfer, no strobes or protection
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`AUD_DATA_W-1:0] pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

/* audio_consts.svh */
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// sample and register word width
`define AUD_DATA_W 32
// decoded apb address, bits 11:2 pick the register
`define APB_ADDR_W 12
// board serial number straps
`define SERIAL_W 3
// pwm counter and brightness width
`define LED_PWM_W 16

// register offsets
`define REG_LEDS            12'h000
`define REG_USB_WR_DATA     12'h004
`define REG_USB_WR_FULL     12'h008
`define REG_USB_RD_DATA     12'h00C
`define REG_USB_RD_EMPTY    12'h010
`define REG_USB_WR_MUX      12'h014
`define REG_DAC_CFG         12'h018
`define REG_DAC_DCE         12'h01C
`define REG_AUD_RATE        12'h020
`define REG_USB_WR_PUSH     12'h024
`define REG_USB_LED_R       12'h028
`define REG_PWR_LED_R       12'h02C
`define REG_LED0_BRIGHTNESS 12'h030
`define REG_LED1_BRIGHTNESS 12'h034
`define REG_SERIAL          12'h038
`define REG_I2C_SEL         12'h03C
`define REG_PBKA_WR_DATA    12'h040
`define REG_PBKA_FULL       12'h044

// queue depths, powers of two
`define USB_FIFO_DEPTH  8
`define PBKA_FIFO_DEPTH 8

// clock cycles per sample tick, scaled down for simulation
`define AUD_DIV_48K  16
`define AUD_DIV_96K  8
`define AUD_DIV_192K 4

`endif

/* audio_ctrl_top.f */
+incdir+.
apb_pkg.sv
audio_pkg.sv
sample_fifo.sv
audio_regs.sv
usb_path.sv
playback_out.sv
led_pwm.sv
audio_ctrl_top.sv
tb_audio_ctrl.sv

/* audio_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// usb audio interface control plane
module audio_ctrl_top
    import apb_pkg::*, audio_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  apb_req_t               apb,
    output logic [`AUD_DATA_W-1:0] prdata,
    input  logic [`SERIAL_W-1:0]   serial,
    input  word_t                  host_rx,
    output logic                   host_rx_ready,
    output word_t                  host_tx,
    input  logic                   host_tx_ready,
    output word_t                  aud_out,
    output dac_ctrl_t              dac,
    output logic                   i2c_sel,
    output logic                   usb_wr_push,
    output logic [1:0]             leds,
    output logic                   usb_led,
    output logic                   pwr_led
);

    word_t                  cpu_tx;
    word_t                  pbka_wr;
    logic                   cpu_rx_pop;
    usb_src_e               usb_src;
    aud_rate_e              aud_rate;
    led_ctrl_t              leds_ctrl;
    logic                   usb_wr_full;
    logic                   usb_rd_empty;
    logic                   pbka_full;
    logic [`AUD_DATA_W-1:0] usb_rd_data;

    audio_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .apb         (apb),
        .prdata      (prdata),
        .usb_wr_full (usb_wr_full),
        .usb_rd_empty(usb_rd_empty),
        .pbka_full   (pbka_full),
        .usb_rd_data (usb_rd_data),
        .serial      (serial),
        .cpu_tx      (cpu_tx),
        .pbka_wr     (pbka_wr),
        .cpu_rx_pop  (cpu_rx_pop),
        .usb_wr_push (usb_wr_push),
        .usb_src     (usb_src),
        .aud_rate    (aud_rate),
        .dac         (dac),
        .leds_ctrl   (leds_ctrl),
        .i2c_sel     (i2c_sel)
    );

    usb_path u_usb (
        .clk          (clk),
        .reset        (reset),
        .usb_src      (usb_src),
        .cpu_tx       (cpu_tx),
        .cpu_rx_pop   (cpu_rx_pop),
        .host_rx      (host_rx),
        .host_rx_ready(host_rx_ready),
        .host_tx      (host_tx),
        .host_tx_ready(host_tx_ready),
        .wr_full      (usb_wr_full),
        .rd_empty     (usb_rd_empty),
        .rd_data      (usb_rd_data)
    );

    playback_out u_playback (
        .clk      (clk),
        .reset    (reset),
        .pbka_wr  (pbka_wr),
        .aud_rate (aud_rate),
        .pbka_full(pbka_full),
        .aud_out  (aud_out)
    );

    led_pwm u_led_pwm (
        .clk      (clk),
        .reset    (reset),
        .leds_ctrl(leds_ctrl),
        .usb_led  (usb_led),
        .pwr_led  (pwr_led)
    );

    // plain board leds straight from the register
    assign leds = leds_ctrl.leds;

endmodule

`default_nettype wire

/* audio_pkg.sv */
`default_nettype none
`include "audio_consts.svh"

package audio_pkg;

    // one stream beat, or one strobed register write
    typedef struct packed {
        logic                   valid;
        logic [`AUD_DATA_W-1:0] data;
    } word_t;

    // usb transmit source, 1 and 2 reserved (analog inputs not built)
    typedef enum logic [1:0] {
        usb_src_cpu      = 2'd0,
        usb_src_loopback = 2'd3
    } usb_src_e;

    // playback rate, code 3 falls back to 48k
    typedef enum logic [1:0] {
        aud_rate_48k  = 2'd0,
        aud_rate_96k  = 2'd1,
        aud_rate_192k = 2'd2
    } aud_rate_e;

    typedef struct packed {
        logic [7:0] cfg;
        // one cycle, cfg is valid with it
        logic       cfg_wr;
        logic       dce;
    } dac_ctrl_t;

    typedef struct packed {
        logic [1:0]            leds;
        logic                  usb_led_r;
        logic                  pwr_led_r;
        logic [`LED_PWM_W-1:0] led0_brightness;
        logic [`LED_PWM_W-1:0] led1_brightness;
    } led_ctrl_t;

endpackage

`default_nettype wire

/* audio_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// apb register block, zero wait states
module audio_regs
    import apb_pkg::*, audio_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  apb_req_t               apb,
    output logic [`AUD_DATA_W-1:0] prdata,
    input  logic                   usb_wr_full,
    input  logic                   usb_rd_empty,
    input  logic                   pbka_full,
    input  logic [`AUD_DATA_W-1:0] usb_rd_data,
    input  logic [`SERIAL_W-1:0]   serial,
    output word_t                  cpu_tx,
    output word_t                  pbka_wr,
    output logic                   cpu_rx_pop,
    output logic                   usb_wr_push,
    output usb_src_e               usb_src,
    output aud_rate_e              aud_rate,
    output dac_ctrl_t              dac,
    output led_ctrl_t              leds_ctrl,
    output logic                   i2c_sel
);

    logic                   access;
    logic                   wr_en;
    logic                   rd_en;
    logic [`APB_ADDR_W-1:0] reg_addr;
    logic                   hit_usb_wr;
    logic                   hit_pbka_wr;
    logic                   tx_valid;
    logic                   pb_valid;
    logic [`AUD_DATA_W-1:0] tx_data;
    logic [`AUD_DATA_W-1:0] pb_data;

    // access phase is psel and penable together
    assign access = apb.psel && apb.penable;
    assign wr_en  = access && apb.pwrite;
    assign rd_en  = access && !apb.pwrite;

    // word aligned offset
    assign reg_addr = {apb.paddr[`APB_ADDR_W-1:2], 2'b00};

    assign hit_usb_wr  = wr_en && (reg_addr == `REG_USB_WR_DATA);
    assign hit_pbka_wr = wr_en && (reg_addr == `REG_PBKA_WR_DATA);

    // settings and one-cycle strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            leds_ctrl   <= '0;
            usb_src     <= usb_src_cpu;
            aud_rate    <= aud_rate_48k;
            dac         <= '0;
            i2c_sel     <= 1'b0;
            tx_valid    <= 1'b0;
            pb_valid    <= 1'b0;
            cpu_rx_pop  <= 1'b0;
            usb_wr_push <= 1'b0;
        end else begin
            // strobes fall again after one cycle
            tx_valid    <= hit_usb_wr;
            pb_valid    <= hit_pbka_wr;
            cpu_rx_pop  <= rd_en && (reg_addr == `REG_USB_RD_DATA);
            usb_wr_push <= wr_en && (reg_addr == `REG_USB_WR_PUSH) && apb.pwdata[0];
            dac.cfg_wr  <= wr_en && (reg_addr == `REG_DAC_CFG);
            if (wr_en) begin
                case (reg_addr)
                    `REG_LEDS:            leds_ctrl.leds <= apb.pwdata[1:0];
                    // reserved source codes are stored as written
                    `REG_USB_WR_MUX:      usb_src <= usb_src_e'(apb.pwdata[1:0]);
                    `REG_DAC_CFG:         dac.cfg <= apb.pwdata[7:0];
                    `REG_DAC_DCE:         dac.dce <= apb.pwdata[0];
                    `REG_AUD_RATE:        aud_rate <= aud_rate_e'(apb.pwdata[1:0]);
                    `REG_USB_LED_R:       leds_ctrl.usb_led_r <= apb.pwdata[0];
                    `REG_PWR_LED_R:       leds_ctrl.pwr_led_r <= apb.pwdata[0];
                    `REG_LED0_BRIGHTNESS: begin
                        leds_ctrl.led0_brightness <= apb.pwdata[`LED_PWM_W-1:0];
                    end
                    `REG_LED1_BRIGHTNESS: begin
                        leds_ctrl.led1_brightness <= apb.pwdata[`LED_PWM_W-1:0];
                    end
                    `REG_I2C_SEL:         i2c_sel <= apb.pwdata[0];
                    default:              ;
                endcase
            end
        end
    end

    // write payloads, held until the next data write
    always_ff @(posedge clk) begin
        if (hit_usb_wr) begin
            tx_data <= apb.pwdata;
        end
        if (hit_pbka_wr) begin
            pb_data <= apb.pwdata;
        end
    end

    assign cpu_tx  = '{valid: tx_valid, data: tx_data};
    assign pbka_wr = '{valid: pb_valid, data: pb_data};

    // read mux, unmapped offsets give zero
    always_comb begin
        prdata = '0;
        case (reg_addr)
            `REG_LEDS:            prdata = `AUD_DATA_W'(leds_ctrl.leds);
            `REG_USB_WR_FULL:     prdata = `AUD_DATA_W'(usb_wr_full);
            // head before the pop that this read triggers
            `REG_USB_RD_DATA:     prdata = usb_rd_data;
            `REG_USB_RD_EMPTY:    prdata = `AUD_DATA_W'(usb_rd_empty);
            `REG_USB_WR_MUX:      prdata = `AUD_DATA_W'(usb_src);
            `REG_DAC_DCE:         prdata = `AUD_DATA_W'(dac.dce);
            `REG_AUD_RATE:        prdata = `AUD_DATA_W'(aud_rate);
            `REG_USB_LED_R:       prdata = `AUD_DATA_W'(leds_ctrl.usb_led_r);
            `REG_PWR_LED_R:       prdata = `AUD_DATA_W'(leds_ctrl.pwr_led_r);
            `REG_LED0_BRIGHTNESS: prdata = `AUD_DATA_W'(leds_ctrl.led0_brightness);
            `REG_LED1_BRIGHTNESS: prdata = `AUD_DATA_W'(leds_ctrl.led1_brightness);
            `REG_SERIAL:          prdata = `AUD_DATA_W'(serial);
            `REG_I2C_SEL:         prdata = `AUD_DATA_W'(i2c_sel);
            `REG_PBKA_FULL:       prdata = `AUD_DATA_W'(pbka_full);
            default:              prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* led_pwm.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// pwm dimmer for the two red status leds
module led_pwm
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  led_ctrl_t leds_ctrl,
    output logic      usb_led,
    output logic      pwr_led
);

    logic [`LED_PWM_W-1:0] pwm_cnt;

    // free running, wraps every 65536 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // on for brightness cycles per period, gated by red enable
    assign usb_led = leds_ctrl.usb_led_r && (pwm_cnt < leds_ctrl.led0_brightness);
    assign pwr_led = leds_ctrl.pwr_led_r && (pwm_cnt < leds_ctrl.led1_brightness);

endmodule

`default_nettype wire

/* playback_out.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// playback queue drained one sample per rate tick
module playback_out
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     pbka_wr,
    input  aud_rate_e aud_rate,
    output logic      pbka_full,
    output word_t     aud_out
);

    // largest reload is 48k divisor minus one
    localparam int cnt_w = $clog2(`AUD_DIV_48K);

    logic [cnt_w-1:0]       tick_cnt;
    logic [cnt_w-1:0]       reload;
    aud_rate_e              rate_q;
    word_t                  head;
    logic                   tick;
    logic                   out_valid;
    logic [`AUD_DATA_W-1:0] out_data;

    // code 3 runs at 48k
    always_comb begin
        case (aud_rate)
            aud_rate_96k:  reload = cnt_w'(`AUD_DIV_96K - 1);
            aud_rate_192k: reload = cnt_w'(`AUD_DIV_192K - 1);
            default:       reload = cnt_w'(`AUD_DIV_48K - 1);
        endcase
    end

    // no tick in the cycle the rate changes
    assign tick = (tick_cnt == '0) && (aud_rate == rate_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt  <= cnt_w'(`AUD_DIV_48K - 1);
            rate_q    <= aud_rate_48k;
            out_valid <= 1'b0;
        end else begin
            rate_q    <= aud_rate;
            out_valid <= tick && head.valid;
            // restart on a new rate, else count down and reload
            if (aud_rate != rate_q || tick_cnt == '0) begin
                tick_cnt <= reload;
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    // sample payload
    always_ff @(posedge clk) begin
        if (tick) begin
            out_data <= head.data;
        end
    end

    sample_fifo #(
        .depth(`PBKA_FIFO_DEPTH)
    ) u_pbka_fifo (
        .clk  (clk),
        .reset(reset),
        .push (pbka_wr),
        .pop  (tick),
        .head (head),
        .full (pbka_full)
    );

    assign aud_out = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

/* sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// first-word-fall-through queue of stream words
module sample_fifo
    import audio_pkg::*;
#(
    parameter int depth = `USB_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t push,
    input  logic  pop,
    output word_t head,
    output logic  full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [`AUD_DATA_W-1:0] mem [0:depth-1];
    logic [ptr_w-1:0]       rd_ptr;
    logic [ptr_w-1:0]       wr_ptr;
    logic [cnt_w-1:0]       count;
    logic                   do_push;
    logic                   do_pop;

    // push on full is dropped, pop on empty ignored
    assign full    = (count == cnt_w'(depth));
    assign do_push = push.valid && !full;
    assign do_pop  = pop && (count != '0);

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head falls through, data reads zero while empty
    assign head.valid = (count != '0);
    assign head.data  = head.valid ? mem[rd_ptr] : '0;

endmodule

`default_nettype wire

/* tb_audio_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// directed testbench for the audio control plane
module tb_audio_ctrl
    import apb_pkg::*, audio_pkg::*;
();

    localparam int clk_period = 100;

    logic                   clk;
    logic                   reset;
    apb_req_t               apb;
    logic [`AUD_DATA_W-1:0] prdata;
    logic [`SERIAL_W-1:0]   serial;
    word_t                  host_rx;
    logic                   host_rx_ready;
    word_t                  host_tx;
    logic                   host_tx_ready;
    word_t                  aud_out;
    dac_ctrl_t              dac;
    logic                   i2c_sel;
    logic                   usb_wr_push;
    logic [1:0]             leds;
    logic                   usb_led;
    logic                   pwr_led;

    int                     err_count   = 0;
    int                     check_count = 0;
    logic [31:0]            rng_state   = 32'd21;
    // words expected on host_tx in arrival order
    logic [31:0]            exp_tx [$];

    audio_ctrl_top DUT (
        .clk          (clk),
        .reset        (reset),
        .apb          (apb),
        .prdata       (prdata),
        .serial       (serial),
        .host_rx      (host_rx),
        .host_rx_ready(host_rx_ready),
        .host_tx      (host_tx),
        .host_tx_ready(host_tx_ready),
        .aud_out      (aud_out),
        .dac          (dac),
        .i2c_sel      (i2c_sel),
        .usb_wr_push  (usb_wr_push),
        .leds         (leds),
        .usb_led      (usb_led),
        .pwr_led      (pwr_led)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_word(input logic [`AUD_DATA_W-1:0] got,
                              input logic [`AUD_DATA_W-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_stream(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t ns: %s, got valid %b data %h expected valid %b data %h",
                     $time, what, got.valid, got.data, exp.valid, exp.data);
        end
    endtask

    task automatic check_dac(input dac_ctrl_t got, input dac_ctrl_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t ns: %s, got cfg %h wr %b dce %b expected cfg %h wr %b dce %b",
                     $time, what, got.cfg, got.cfg_wr, got.dce, exp.cfg, exp.cfg_wr, exp.dce);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%-10s passed", name);
        end else begin
            $display("%-10s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // setup and access phases plus an idle cycle, returning on its falling edge
    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        apb.pwdata  = '0;
        @(negedge clk);
        apb.penable = 1'b1;
        // prdata settled mid access phase
        #(clk_period / 4);
        data = prdata;
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic read_expect(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] got;
        apb_read(addr, got);
        check_word(got, exp, what);
    endtask

    // one host beat once the receive queue has room
    task automatic host_send(input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!host_rx_ready && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!host_rx_ready) begin
            stop_on_timeout("host_rx_ready");
        end
        host_rx = {1'b1, data};
        @(negedge clk);
        host_rx = '0;
    endtask

    // raise host_tx_ready, match beats against exp_tx, then expect silence
    task automatic drain_tx(input string what);
        int waited;
        int seen;
        waited = 0;
        seen   = 0;
        @(negedge clk);
        host_tx_ready = 1'b1;
        while (seen < exp_tx.size() && waited < 200) begin
            if (host_tx.valid) begin
                check_stream(host_tx, {1'b1, exp_tx[seen]}, what);
                seen++;
            end
            @(negedge clk);
            waited++;
        end
        if (seen < exp_tx.size()) begin
            stop_on_timeout({what, " beats on host_tx"});
        end
        repeat (20) begin
            if (host_tx.valid) begin
                check_stream(host_tx, '0, {what, " unexpected beat"});
            end
            @(negedge clk);
        end
        host_tx_ready = 1'b0;
    endtask

    task automatic defaults_readback();
        logic [`APB_ADDR_W-1:0] offs [9];
        logic [31:0]            masks [9];
        logic [31:0]            vals [9];
        logic [31:0]            exp;
        logic [31:0]            w;
        int                     errs;
        errs = err_count;
        // empty flag is the only live bit set after reset
        for (int a = 0; a <= 'h44; a += 4) begin
            if (a == `REG_USB_RD_EMPTY) begin
                exp = 32'd1;
            end else if (a == `REG_SERIAL) begin
                exp = 32'(serial);
            end else begin
                exp = '0;
            end
            read_expect(12'(a), exp, "reset value");
        end
        read_expect(12'h048, '0, "unmapped offset");
        read_expect(12'hffc, '0, "unmapped offset");
        offs[0] = `REG_LEDS;
        masks[0] = 32'h3;
        offs[1] = `REG_USB_WR_MUX;
        masks[1] = 32'h3;
        offs[2] = `REG_DAC_DCE;
        masks[2] = 32'h1;
        offs[3] = `REG_AUD_RATE;
        masks[3] = 32'h3;
        offs[4] = `REG_USB_LED_R;
        masks[4] = 32'h1;
        offs[5] = `REG_PWR_LED_R;
        masks[5] = 32'h1;
        offs[6] = `REG_LED0_BRIGHTNESS;
        masks[6] = 32'hffff;
        offs[7] = `REG_LED1_BRIGHTNESS;
        masks[7] = 32'hffff;
        offs[8] = `REG_I2C_SEL;
        masks[8] = 32'h1;
        for (int i = 0; i < 9; i++) begin
            vals[i] = next_rand();
            apb_write(offs[i], vals[i]);
        end
        for (int i = 0; i < 9; i++) begin
            read_expect(offs[i], vals[i] & masks[i], "masked readback");
        end
        check_word(32'(leds), vals[0] & 32'h3, "leds output");
        check_word(32'(i2c_sel), vals[8] & 32'h1, "i2c_sel output");
        // cfg never written yet, so only dce may be set
        check_dac(dac, {8'h00, 1'b0, vals[2][0]}, "dac dce output");
        for (int i = 0; i < 9; i++) begin
            apb_write(offs[i], '0);
        end
        // cfg strobe lasts one cycle
        check_dac(dac, '0, "dac idle");
        w = next_rand();
        apb_write(`REG_DAC_CFG, w);
        check_dac(dac, {w[7:0], 1'b1, 1'b0}, "dac cfg strobe");
        @(negedge clk);
        check_dac(dac, {w[7:0], 1'b0, 1'b0}, "dac cfg after strobe");
        apb_write(`REG_USB_WR_PUSH, 32'h0);
        check_word(32'(usb_wr_push), '0, "usb_wr_push with bit 0 clear");
        apb_write(`REG_USB_WR_PUSH, 32'h1);
        check_word(32'(usb_wr_push), 32'd1, "usb_wr_push strobe");
        @(negedge clk);
        check_word(32'(usb_wr_push), '0, "usb_wr_push after strobe");
        report_test("defaults", errs);
    endtask

    task automatic transmit_to_host();
        logic [31:0] w;
        int          errs;
        errs = err_count;
        exp_tx.delete();
        // two words past full are dropped
        for (int i = 0; i < `USB_FIFO_DEPTH + 2; i++) begin
            w = next_rand();
            apb_write(`REG_USB_WR_DATA, w);
            if (i < `USB_FIFO_DEPTH) begin
                exp_tx.push_back(w);
            end
        end
        read_expect(`REG_USB_WR_FULL, 32'd1, "usb tx full flag");
        drain_tx("usb tx");
        read_expect(`REG_USB_WR_FULL, '0, "usb tx full flag after drain");
        report_test("usb_tx", errs);
    endtask

    task automatic receive_from_host();
        logic [31:0] words [`USB_FIFO_DEPTH];
        int          errs;
        errs = err_count;
        for (int i = 0; i < `USB_FIFO_DEPTH; i++) begin
            words[i] = next_rand();
            host_send(words[i]);
        end
        check_word(32'(host_rx_ready), '0, "host_rx_ready when full");
        read_expect(`REG_USB_RD_EMPTY, '0, "usb rx empty flag");
        for (int i = 0; i < `USB_FIFO_DEPTH; i++) begin
            read_expect(`REG_USB_RD_DATA, words[i], "usb rx data");
        end
        read_expect(`REG_USB_RD_EMPTY, 32'd1, "usb rx empty flag after reads");
        report_test("usb_rx", errs);
    endtask

    task automatic loopback_moves();
        logic [31:0] w;
        int          errs;
        errs = err_count;
        apb_write(`REG_USB_WR_MUX, 32'd3);
        exp_tx.delete();
        // cpu writes mixed in must never reach host_tx
        for (int i = 0; i < 5; i++) begin
            w = next_rand();
            host_send(w);
            exp_tx.push_back(w);
            if (i == 2) begin
                apb_write(`REG_USB_WR_DATA, next_rand());
            end
        end
        apb_write(`REG_USB_WR_DATA, next_rand());
        read_expect(`REG_USB_RD_EMPTY, 32'd1, "rx queue after loopback moves");
        drain_tx("loopback");
        apb_write(`REG_USB_WR_MUX, '0);
        report_test("loopback", errs);
    endtask

    task automatic playback_rates();
        logic [31:0] samples [4];
        int          divs [4];
        int          errs;
        int          beats;
        int          waited;
        int          last;
        errs = err_count;
        divs[0] = `AUD_DIV_48K;
        divs[1] = `AUD_DIV_96K;
        divs[2] = `AUD_DIV_192K;
        // code 3 behaves as 48k
        divs[3] = `AUD_DIV_48K;
        for (int r = 0; r < 4; r++) begin
            apb_write(`REG_AUD_RATE, 32'(r));
            for (int i = 0; i < 4; i++) begin
                samples[i] = next_rand();
            end
            beats  = 0;
            waited = 0;
            last   = 0;
            fork
                begin
                    for (int i = 0; i < 4; i++) begin
                        apb_write(`REG_PBKA_WR_DATA, samples[i]);
                    end
                end
                begin
                    while (beats < 4 && waited < 300) begin
                        @(negedge clk);
                        waited++;
                        if (aud_out.valid) begin
                            check_stream(aud_out, {1'b1, samples[beats]}, "aud_out sample");
                            if (beats > 0) begin
                                check_word(32'(waited - last), 32'(divs[r]), "aud_out spacing");
                            end
                            last = waited;
                            beats++;
                        end
                    end
                end
            join
            if (beats < 4) begin
                stop_on_timeout("playback samples on aud_out");
            end
            repeat (3 * divs[r]) begin
                @(negedge clk);
                if (aud_out.valid) begin
                    check_stream(aud_out, '0, "aud_out after drain");
                end
            end
        end
        apb_write(`REG_AUD_RATE, '0);
        report_test("playback", errs);
    endtask

    task automatic led_dimming();
        logic [15:0] b0;
        logic [15:0] b1;
        int          on0;
        int          on1;
        int          errs;
        errs = err_count;
        b0 = 16'(next_rand());
        b1 = 16'(next_rand());
        apb_write(`REG_LED0_BRIGHTNESS, 32'(b0));
        apb_write(`REG_LED1_BRIGHTNESS, 32'(b1));
        apb_write(`REG_USB_LED_R, 32'd1);
        apb_write(`REG_PWR_LED_R, 32'd1);
        on0 = 0;
        on1 = 0;
        // one full pwm period
        repeat (65536) begin
            @(negedge clk);
            on0 += int'(usb_led);
            on1 += int'(pwr_led);
        end
        check_word(32'(on0), 32'(b0), "usb_led on cycles");
        check_word(32'(on1), 32'(b1), "pwr_led on cycles");
        apb_write(`REG_USB_LED_R, '0);
        apb_write(`REG_PWR_LED_R, '0);
        on0 = 0;
        on1 = 0;
        // whole period again so the counter passes below both brightness values
        repeat (65536) begin
            @(negedge clk);
            on0 += int'(usb_led);
            on1 += int'(pwr_led);
        end
        check_word(32'(on0), '0, "usb_led with enable clear");
        check_word(32'(on1), '0, "pwr_led with enable clear");
        report_test("leds", errs);
    endtask

    initial begin
        apb           = '0;
        serial        = 3'b101;
        host_rx       = '0;
        host_tx_ready = 1'b0;
        reset         = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        defaults_readback();
        transmit_to_host();
        receive_from_host();
        loopback_moves();
        playback_rates();
        led_dimming();
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* usb_path.sv */
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

// usb transmit and receive queues with loopback mover
module usb_path
    import audio_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  usb_src_e               usb_src,
    input  word_t                  cpu_tx,
    input  logic                   cpu_rx_pop,
    input  word_t                  host_rx,
    output logic                   host_rx_ready,
    output word_t                  host_tx,
    input  logic                   host_tx_ready,
    output logic                   wr_full,
    output logic                   rd_empty,
    output logic [`AUD_DATA_W-1:0] rd_data
);

    word_t tx_push;
    word_t tx_head;
    word_t rx_head;
    logic  tx_full;
    logic  rx_full;
    logic  rx_pop;
    logic  move;

    // loopback moves one word per cycle when both sides allow
    assign move = (usb_src == usb_src_loopback) && rx_head.valid && !tx_full;

    // transmit input and receive pop by source
    always_comb begin
        tx_push = '0;
        rx_pop  = cpu_rx_pop;
        case (usb_src)
            usb_src_cpu: tx_push = cpu_tx;
            usb_src_loopback: begin
                tx_push = '{valid: move, data: rx_head.data};
                rx_pop  = move;
            end
            // reserved codes write nothing
            default: tx_push = '0;
        endcase
    end

    sample_fifo #(
        .depth(`USB_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk  (clk),
        .reset(reset),
        .push (tx_push),
        .pop  (host_tx_ready),
        .head (tx_head),
        .full (tx_full)
    );

    // host beats land straight in the receive queue
    sample_fifo #(
        .depth(`USB_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk  (clk),
        .reset(reset),
        .push (host_rx),
        .pop  (rx_pop),
        .head (rx_head),
        .full (rx_full)
    );

    assign host_tx       = tx_head;
    assign host_rx_ready = !rx_full;
    assign wr_full       = tx_full;
    assign rd_empty      = !rx_head.valid;
    assign rd_data       = rx_head.data;

endmodule

`default_nettype wire
